// File: list.f
src/soc_pkg.sv
src/bus_decoder.sv
src/onchip_ram.sv
src/timer_block.sv
src/irq_ctrl.sv
src/soc_top.sv
dv/soc_properties.sv
dv/tb_soc.sv

// File: run.sh
#!/bin/sh
# build and run tb_soc with Verilator, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_soc \
	-Mdir obj_dir -o tb_soc > build.log 2>&1 \
	&& ./obj_dir/tb_soc > sim.log 2>&1 \
	&& grep -q "PASS: all tests" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see build.log and sim.log"; exit 1; }

// File: dv/tb_soc.sv
// directed tests for soc_top with 4 timers, the testbench is the only master; limits in cycles
`timescale 1ns/100ps

module tb_soc;

	localparam int NUM_TIMERS  = 4;
	localparam int RAM_WORDS   = 1024;
	localparam int BUS_TIMEOUT = 20;
	localparam int IRQ_TIMEOUT = 200;

	logic             clk;
	logic             i_rst_n;
	soc_pkg::wb_req_t wb_req;
	soc_pkg::wb_rsp_t wb_rsp;
	logic             irq;
	int               errors;

	soc_top #(.NUM_TIMERS(NUM_TIMERS), .RAM_WORDS(RAM_WORDS)) u_dut (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.i_wb    (wb_req),
		.o_wb    (wb_rsp),
		.o_irq   (irq)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check(input string name, input logic [31:0] expected,
			     input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
			errors++;
		end
	endtask

	// one classic cycle, entered and left 1 ns after a rising edge
	task automatic bus_cycle(input logic we, input logic [31:0] byte_adr,
				 input soc_pkg::bus_sel_t sel, input soc_pkg::bus_data_t wdata,
				 output soc_pkg::bus_data_t rdata, output logic ack, output logic err);
		int waited;
		waited = 0;
		rdata = '0;
		ack = 1'b0;
		err = 1'b0;
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: byte_adr[31:2], sel: sel, dat: wdata};
		do begin
			@(posedge clk);
			#1;
			waited++;
		end while (!(wb_rsp.ack || wb_rsp.err) && waited < BUS_TIMEOUT);
		if (wb_rsp.ack || wb_rsp.err) begin
			ack = wb_rsp.ack;
			err = wb_rsp.err;
			rdata = wb_rsp.dat;
		end else begin
			$display("bus access to %h got neither ack nor err within %0d cycles",
				 byte_adr, BUS_TIMEOUT);
			errors++;
		end
		wb_req.cyc = 1'b0;
		wb_req.stb = 1'b0;
		wb_req.we = 1'b0;
		// one idle cycle between accesses
		@(posedge clk);
		#1;
	endtask

	task automatic bus_write(input logic [31:0] byte_adr, input soc_pkg::bus_sel_t sel,
				 input soc_pkg::bus_data_t wdata, output logic ack, output logic err);
		soc_pkg::bus_data_t unused_dat;
		bus_cycle(1'b1, byte_adr, sel, wdata, unused_dat, ack, err);
	endtask

	task automatic bus_read(input logic [31:0] byte_adr, output soc_pkg::bus_data_t rdata,
				output logic ack, output logic err);
		bus_cycle(1'b0, byte_adr, 4'hf, '0, rdata, ack, err);
	endtask

	// full-word accesses that must end with ack
	task automatic write_reg(input logic [31:0] byte_adr, input soc_pkg::bus_data_t wdata);
		logic ack;
		logic err;
		bus_write(byte_adr, 4'hf, wdata, ack, err);
		check("write ack", 32'd1, 32'(ack));
		check("write err", 32'd0, 32'(err));
	endtask

	task automatic read_reg(input logic [31:0] byte_adr, output soc_pkg::bus_data_t rdata);
		logic ack;
		logic err;
		bus_read(byte_adr, rdata, ack, err);
		check("read ack", 32'd1, 32'(ack));
		check("read err", 32'd0, 32'(err));
	endtask

	function automatic logic [31:0] tmr_addr(input int idx, input soc_pkg::reg_ofs_t ofs);
		return soc_pkg::TIMER_BASE + 32'(idx) * 32'(soc_pkg::TMR_STRIDE) + 32'(ofs);
	endfunction

	function automatic logic [31:0] irq_addr(input soc_pkg::reg_ofs_t ofs);
		return soc_pkg::IRQ_BASE + 32'(ofs);
	endfunction

	function automatic logic [31:0] lane_mask(input soc_pkg::bus_sel_t sel);
		logic [31:0] mask;
		for (int b = 0; b < 4; b++) begin
			mask[8*b +: 8] = {8{sel[b]}};
		end
		return mask;
	endfunction

	task automatic reset_test();
		soc_pkg::bus_data_t rdata;
		check("o_irq after reset", 32'd0, 32'(irq));
		read_reg(irq_addr(soc_pkg::IRQ_ENABLE_OFS), rdata);
		check("irq enable after reset", 32'd0, rdata);
		read_reg(irq_addr(soc_pkg::IRQ_STATUS_OFS), rdata);
		check("irq status after reset", 32'd0, rdata);
		for (int i = 0; i < NUM_TIMERS; i++) begin
			read_reg(tmr_addr(i, soc_pkg::TMR_COUNT_OFS), rdata);
			check("timer count after reset", 32'd0, rdata);
		end
	endtask

	task automatic ram_test();
		int                 words [4] = '{0, 1, 37, RAM_WORDS - 1};
		soc_pkg::bus_data_t expected [4];
		soc_pkg::bus_data_t rdata;
		soc_pkg::bus_data_t wdata;
		logic               ack;
		logic               err;
		for (int k = 0; k < 4; k++) begin
			expected[k] = $urandom;
			write_reg(soc_pkg::RAM_BASE + 32'(words[k]) * 32'd4, expected[k]);
		end
		for (int k = 0; k < 4; k++) begin
			read_reg(soc_pkg::RAM_BASE + 32'(words[k]) * 32'd4, rdata);
			check("ram read data", expected[k], rdata);
		end
		// bytes 0 and 2 only
		wdata = $urandom;
		bus_write(soc_pkg::RAM_BASE + 32'd4, 4'b0101, wdata, ack, err);
		check("partial write ack", 32'd1, 32'(ack));
		check("partial write err", 32'd0, 32'(err));
		expected[1] = (expected[1] & ~lane_mask(4'b0101)) | (wdata & lane_mask(4'b0101));
		read_reg(soc_pkg::RAM_BASE + 32'd4, rdata);
		check("ram data after partial write", expected[1], rdata);
	endtask

	task automatic unmapped_test();
		soc_pkg::bus_data_t rdata;
		logic               ack;
		logic               err;
		bus_write(32'h4000_0000, 4'hf, 32'hdead_beef, ack, err);
		check("unmapped write ack", 32'd0, 32'(ack));
		check("unmapped write err", 32'd1, 32'(err));
		bus_read(32'h4000_0000, rdata, ack, err);
		check("unmapped read ack", 32'd0, 32'(ack));
		check("unmapped read err", 32'd1, 32'(err));
		check("unmapped read data", 32'd0, rdata);
		bus_read(tmr_addr(NUM_TIMERS, soc_pkg::TMR_COUNT_OFS), rdata, ack, err);
		check("bad timer index ack", 32'd0, 32'(ack));
		check("bad timer index err", 32'd1, 32'(err));
	endtask

	task automatic timer_irq_test();
		soc_pkg::bus_data_t rdata;
		int                 waited;
		write_reg(tmr_addr(0, soc_pkg::TMR_RELOAD_OFS), 32'd20);
		write_reg(irq_addr(soc_pkg::IRQ_ENABLE_OFS), 32'h1);
		write_reg(tmr_addr(0, soc_pkg::TMR_CTRL_OFS), 32'h1);
		waited = 0;
		while (!irq && waited < IRQ_TIMEOUT) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (!irq) begin
			$display("o_irq did not rise within %0d cycles of enabling timer 0", IRQ_TIMEOUT);
			errors++;
		end
		read_reg(irq_addr(soc_pkg::IRQ_STATUS_OFS), rdata);
		check("irq status bit 0", 32'd1, 32'(rdata[0]));
		read_reg(tmr_addr(0, soc_pkg::TMR_COUNT_OFS), rdata);
		check("timer 0 count within reload", 32'd1, 32'(rdata <= 32'd20));
		write_reg(tmr_addr(0, soc_pkg::TMR_CTRL_OFS), 32'h0);
		write_reg(irq_addr(soc_pkg::IRQ_CLEAR_OFS), 32'h1);
		write_reg(irq_addr(soc_pkg::IRQ_ENABLE_OFS), 32'h0);
	endtask

	task automatic mask_clear_test();
		soc_pkg::bus_data_t rdata;
		int                 waited;
		write_reg(tmr_addr(1, soc_pkg::TMR_RELOAD_OFS), 32'd10);
		write_reg(tmr_addr(1, soc_pkg::TMR_CTRL_OFS), 32'h1);
		waited = 0;
		rdata = '0;
		while (!rdata[1] && waited < IRQ_TIMEOUT) begin
			read_reg(irq_addr(soc_pkg::IRQ_STATUS_OFS), rdata);
			check("o_irq while masked", 32'd0, 32'(irq));
			waited++;
		end
		if (!rdata[1]) begin
			$display("status bit 1 was not set within %0d reads", IRQ_TIMEOUT);
			errors++;
		end
		write_reg(irq_addr(soc_pkg::IRQ_ENABLE_OFS), 32'h2);
		check("o_irq after enable", 32'd1, 32'(irq));
		write_reg(tmr_addr(1, soc_pkg::TMR_CTRL_OFS), 32'h0);
		write_reg(irq_addr(soc_pkg::IRQ_CLEAR_OFS), 32'h2);
		read_reg(irq_addr(soc_pkg::IRQ_STATUS_OFS), rdata);
		check("irq status after clear", 32'd0, rdata);
		check("o_irq after clear", 32'd0, 32'(irq));
	endtask

	initial begin
		errors = 0;
		void'($urandom(32'h7bd0_99d0));
		i_rst_n = 1'b0;
		wb_req = '0;
		repeat (3) @(posedge clk);
		#1;
		i_rst_n = 1'b1;
		reset_test();
		ram_test();
		unmapped_test();
		timer_irq_test();
		mask_clear_test();
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: dv/soc_properties.sv
// bound to soc_top; bus checks are off during reset, the irq check covers the reset itself
`timescale 1ns/100ps

module soc_properties (
	input logic             clk,
	input logic             i_rst_n,
	input soc_pkg::wb_req_t i_wb_req,
	input soc_pkg::wb_rsp_t i_wb_rsp,
	input logic             i_irq
);

	a_ack_err_excl: assert property (@(posedge clk) disable iff (!i_rst_n)
		!(i_wb_rsp.ack && i_wb_rsp.err))
		else $error("ack and err are high in the same cycle");

	// every response answers a strobe seen one clock earlier
	a_rsp_after_strobe: assert property (@(posedge clk) disable iff (!i_rst_n)
		(i_wb_rsp.ack || i_wb_rsp.err) |-> $past(i_wb_req.cyc && i_wb_req.stb))
		else $error("response without a strobe in the previous cycle");

	a_irq_low_after_reset: assert property (@(posedge clk) !i_rst_n |=> !i_irq)
		else $error("o_irq is high in the cycle after reset");

endmodule

bind soc_top soc_properties u_props (
	.clk      (clk),
	.i_rst_n  (i_rst_n),
	.i_wb_req (i_wb),
	.i_wb_rsp (o_wb),
	.i_irq    (o_irq)
);

// File: src/soc_top.sv
// one bus master only; every access completes one clock after its first strobe cycle
`timescale 1ns/100ps

module soc_top #(
	parameter int NUM_TIMERS = 4,
	parameter int RAM_WORDS  = 1024
) (
	input  logic             clk,
	input  logic             i_rst_n,
	input  soc_pkg::wb_req_t i_wb,
	output soc_pkg::wb_rsp_t o_wb,
	output logic             o_irq
);

	soc_pkg::wb_req_t      ram_req;
	soc_pkg::wb_req_t      tmr_req;
	soc_pkg::wb_req_t      irq_req;
	soc_pkg::wb_rsp_t      ram_rsp;
	soc_pkg::wb_rsp_t      tmr_rsp;
	soc_pkg::wb_rsp_t      irq_rsp;
	logic [NUM_TIMERS-1:0] ticks;

	bus_decoder u_decoder (
		.clk       (clk),
		.i_rst_n   (i_rst_n),
		.i_wb      (i_wb),
		.o_wb      (o_wb),
		.o_ram_req (ram_req),
		.o_tmr_req (tmr_req),
		.o_irq_req (irq_req),
		.i_ram_rsp (ram_rsp),
		.i_tmr_rsp (tmr_rsp),
		.i_irq_rsp (irq_rsp)
	);

	onchip_ram #(.RAM_WORDS(RAM_WORDS)) u_ram (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.i_wb    (ram_req),
		.o_wb    (ram_rsp)
	);

	timer_block #(.NUM_TIMERS(NUM_TIMERS)) u_timers (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.i_wb    (tmr_req),
		.o_wb    (tmr_rsp),
		.o_tick  (ticks)
	);

	// timer n drives interrupt source n
	irq_ctrl #(.NUM_TIMERS(NUM_TIMERS)) u_irq (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.i_wb    (irq_req),
		.o_wb    (irq_rsp),
		.i_src   (ticks),
		.o_irq   (o_irq)
	);

endmodule

// File: src/irq_ctrl.sv
// NUM_TIMERS from 1 to 8, all sources live in byte lane 0; a pulse beats a same-cycle clear
`timescale 1ns/100ps

module irq_ctrl #(
	parameter int NUM_TIMERS = 4
) (
	input  logic                  clk,
	input  logic                  i_rst_n,
	input  soc_pkg::wb_req_t      i_wb,
	output soc_pkg::wb_rsp_t      o_wb,
	input  logic [NUM_TIMERS-1:0] i_src,
	output logic                  o_irq
);

	logic [NUM_TIMERS-1:0] status_q;
	logic [NUM_TIMERS-1:0] enable_q;
	logic [NUM_TIMERS-1:0] clr;
	soc_pkg::reg_ofs_t     ofs;
	soc_pkg::bus_data_t    rdata;
	soc_pkg::wb_rsp_t      rsp_q;
	logic                  acc;
	logic                  wr;

	assign ofs = soc_pkg::reg_ofs_t'({i_wb.adr, 2'b00} - soc_pkg::IRQ_BASE);
	assign acc = i_wb.cyc & i_wb.stb & ~rsp_q.ack;
	assign wr  = acc & i_wb.we & i_wb.sel[0];
	// write one to clear
	assign clr = (wr && ofs == soc_pkg::IRQ_CLEAR_OFS) ? i_wb.dat[NUM_TIMERS-1:0] : '0;

	always_comb begin
		rdata = '0;
		case (ofs)
			soc_pkg::IRQ_STATUS_OFS: rdata[NUM_TIMERS-1:0] = status_q;
			soc_pkg::IRQ_ENABLE_OFS: rdata[NUM_TIMERS-1:0] = enable_q;
			default:                 rdata = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			status_q <= '0;
			enable_q <= '0;
		end else begin
			status_q <= (status_q & ~clr) | i_src;
			if (wr && ofs == soc_pkg::IRQ_ENABLE_OFS) begin
				enable_q <= i_wb.dat[NUM_TIMERS-1:0];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			rsp_q <= '0;
		end else begin
			rsp_q.ack <= acc;
			rsp_q.err <= 1'b0;
			rsp_q.dat <= (acc && !i_wb.we) ? rdata : '0;
		end
	end

	assign o_wb  = rsp_q;
	assign o_irq = |(status_q & enable_q);

endmodule

// File: src/timer_block.sv
// NUM_TIMERS from 1 to 8; count is read only, a write of enable=1 restarts from reload
`timescale 1ns/100ps

module timer_block #(
	parameter int NUM_TIMERS = 4
) (
	input  logic                  clk,
	input  logic                  i_rst_n,
	input  soc_pkg::wb_req_t      i_wb,
	output soc_pkg::wb_rsp_t      o_wb,
	output logic [NUM_TIMERS-1:0] o_tick
);

	localparam int STRIDE_SH = $clog2(soc_pkg::TMR_STRIDE);

	soc_pkg::bus_data_t    count_q  [NUM_TIMERS];
	soc_pkg::bus_data_t    reload_q [NUM_TIMERS];
	logic [NUM_TIMERS-1:0] en_q;
	logic [NUM_TIMERS-1:0] tick_q;
	logic [NUM_TIMERS-1:0] idx_hit;
	soc_pkg::reg_ofs_t     ofs;
	soc_pkg::reg_ofs_t     tmr_idx;
	soc_pkg::reg_ofs_t     reg_ofs;
	soc_pkg::bus_data_t    rdata;
	soc_pkg::wb_rsp_t      rsp_q;
	logic                  valid;
	logic                  acc;
	logic                  wr;

	assign ofs     = soc_pkg::reg_ofs_t'({i_wb.adr, 2'b00} - soc_pkg::TIMER_BASE);
	assign tmr_idx = ofs >> STRIDE_SH;
	assign reg_ofs = ofs & (soc_pkg::TMR_STRIDE - 12'd1);
	assign acc     = i_wb.cyc & i_wb.stb & ~rsp_q.ack & ~rsp_q.err;
	assign valid   = |idx_hit;
	assign wr      = acc & valid & i_wb.we;

	// read mux over the addressed timer, nothing selected past NUM_TIMERS
	always_comb begin
		rdata = '0;
		for (int i = 0; i < NUM_TIMERS; i++) begin
			idx_hit[i] = (tmr_idx == soc_pkg::reg_ofs_t'(i));
			if (idx_hit[i]) begin
				case (reg_ofs)
					soc_pkg::TMR_COUNT_OFS:  rdata = count_q[i];
					soc_pkg::TMR_RELOAD_OFS: rdata = reload_q[i];
					soc_pkg::TMR_CTRL_OFS:   rdata = {31'd0, en_q[i]};
					default:                 rdata = '0;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < NUM_TIMERS; i++) begin
			if (wr && idx_hit[i] && reg_ofs == soc_pkg::TMR_RELOAD_OFS) begin
				for (int b = 0; b < 4; b++) begin
					if (i_wb.sel[b]) begin
						reload_q[i][8*b +: 8] <= i_wb.dat[8*b +: 8];
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			en_q   <= '0;
			tick_q <= '0;
			for (int i = 0; i < NUM_TIMERS; i++) begin
				count_q[i] <= '0;
			end
		end else begin
			for (int i = 0; i < NUM_TIMERS; i++) begin
				tick_q[i] <= 1'b0;
				if (en_q[i]) begin
					if (count_q[i] == '0) begin
						// period is reload + 1 clocks
						count_q[i] <= reload_q[i];
						tick_q[i]  <= 1'b1;
					end else begin
						count_q[i] <= count_q[i] - 32'd1;
					end
				end
				if (wr && idx_hit[i] && reg_ofs == soc_pkg::TMR_CTRL_OFS && i_wb.sel[0]) begin
					en_q[i] <= i_wb.dat[0];
					if (i_wb.dat[0]) begin
						count_q[i] <= reload_q[i];
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			rsp_q <= '0;
		end else begin
			rsp_q.ack <= acc & valid;
			rsp_q.err <= acc & ~valid;
			rsp_q.dat <= (acc && valid && !i_wb.we) ? rdata : '0;
		end
	end

	assign o_wb   = rsp_q;
	assign o_tick = tick_q;

endmodule

// File: src/onchip_ram.sv
// RAM_WORDS must be a power of two of at least 2; larger windows alias, contents not reset
`timescale 1ns/100ps

module onchip_ram #(
	parameter int RAM_WORDS = 1024
) (
	input  logic             clk,
	input  logic             i_rst_n,
	input  soc_pkg::wb_req_t i_wb,
	output soc_pkg::wb_rsp_t o_wb
);

	localparam int AW = $clog2(RAM_WORDS);

	soc_pkg::bus_data_t mem [RAM_WORDS];
	soc_pkg::wb_rsp_t   rsp_q;
	logic [AW-1:0]      idx;
	logic               acc;

	assign idx = i_wb.adr[AW-1:0];
	// a new access is taken only when no ack is pending
	assign acc = i_wb.cyc & i_wb.stb & ~rsp_q.ack;

	always_ff @(posedge clk) begin
		if (acc && i_wb.we) begin
			for (int b = 0; b < 4; b++) begin
				if (i_wb.sel[b]) begin
					mem[idx][8*b +: 8] <= i_wb.dat[8*b +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			rsp_q <= '0;
		end else begin
			rsp_q.ack <= acc;
			rsp_q.err <= 1'b0;
			// read data only while ack is high
			rsp_q.dat <= (acc && !i_wb.we) ? mem[idx] : '0;
		end
	end

	assign o_wb = rsp_q;

endmodule

// File: src/bus_decoder.sv
// single master only; the address must stay stable until ack or err, unmapped strobes get err
`timescale 1ns/100ps

module bus_decoder (
	input  logic             clk,
	input  logic             i_rst_n,
	input  soc_pkg::wb_req_t i_wb,
	output soc_pkg::wb_rsp_t o_wb,
	output soc_pkg::wb_req_t o_ram_req,
	output soc_pkg::wb_req_t o_tmr_req,
	output soc_pkg::wb_req_t o_irq_req,
	input  soc_pkg::wb_rsp_t i_ram_rsp,
	input  soc_pkg::wb_rsp_t i_tmr_rsp,
	input  soc_pkg::wb_rsp_t i_irq_rsp
);

	function automatic logic in_window(soc_pkg::bus_addr_t adr, logic [31:0] base,
					   logic [31:0] span);
		logic [31:0] byte_adr;
		byte_adr = {adr, 2'b00};
		return (byte_adr >= base) && ((byte_adr - base) < span);
	endfunction

	logic             ram_hit;
	logic             tmr_hit;
	logic             irq_hit;
	logic             strobe;
	logic             dflt_err_q;
	soc_pkg::wb_rsp_t sel_rsp;

	assign ram_hit = in_window(i_wb.adr, soc_pkg::RAM_BASE, soc_pkg::RAM_SPAN);
	assign tmr_hit = in_window(i_wb.adr, soc_pkg::TIMER_BASE, soc_pkg::TIMER_SPAN);
	assign irq_hit = in_window(i_wb.adr, soc_pkg::IRQ_BASE, soc_pkg::IRQ_SPAN);
	assign strobe  = i_wb.cyc & i_wb.stb;

	// each slave sees the whole request, only cyc and stb are qualified
	always_comb begin
		o_ram_req     = i_wb;
		o_ram_req.cyc = i_wb.cyc & ram_hit;
		o_ram_req.stb = i_wb.stb & ram_hit;
		o_tmr_req     = i_wb;
		o_tmr_req.cyc = i_wb.cyc & tmr_hit;
		o_tmr_req.stb = i_wb.stb & tmr_hit;
		o_irq_req     = i_wb;
		o_irq_req.cyc = i_wb.cyc & irq_hit;
		o_irq_req.stb = i_wb.stb & irq_hit;
	end

	// default responder, one err per strobe so the master never stalls
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			dflt_err_q <= 1'b0;
		end else begin
			dflt_err_q <= strobe & ~(ram_hit | tmr_hit | irq_hit) & ~dflt_err_q;
		end
	end

	always_comb begin
		if (ram_hit) begin
			sel_rsp = i_ram_rsp;
		end else if (tmr_hit) begin
			sel_rsp = i_tmr_rsp;
		end else if (irq_hit) begin
			sel_rsp = i_irq_rsp;
		end else begin
			sel_rsp = '{ack: 1'b0, err: dflt_err_q, dat: '0};
		end
		o_wb     = sel_rsp;
		o_wb.dat = sel_rsp.err ? '0 : sel_rsp.dat;
	end

endmodule

// File: src/soc_pkg.sv
// windows must be 4 KiB aligned; register offsets are byte offsets within a 4 KiB page
package soc_pkg;

	// word address, byte address bits 31..2
	typedef logic [29:0] bus_addr_t;
	typedef logic [31:0] bus_data_t;
	typedef logic [3:0]  bus_sel_t;
	// byte offset inside one 4 KiB slave page
	typedef logic [11:0] reg_ofs_t;

	typedef struct packed {
		logic      cyc;
		logic      stb;
		logic      we;
		bus_addr_t adr;
		bus_sel_t  sel;
		bus_data_t dat;
	} wb_req_t;

	typedef struct packed {
		logic      ack;
		logic      err;
		bus_data_t dat;
	} wb_rsp_t;

	// byte address map
	localparam logic [31:0] RAM_BASE   = 32'h2000_0000;
	localparam logic [31:0] RAM_SPAN   = 32'h0000_1000;
	localparam logic [31:0] TIMER_BASE = 32'h8000_1000;
	localparam logic [31:0] TIMER_SPAN = 32'h0000_1000;
	localparam logic [31:0] IRQ_BASE   = 32'h8000_2000;
	localparam logic [31:0] IRQ_SPAN   = 32'h0000_1000;

	// timer registers, repeated every TMR_STRIDE bytes
	localparam reg_ofs_t TMR_COUNT_OFS  = 12'h000;
	localparam reg_ofs_t TMR_RELOAD_OFS = 12'h004;
	localparam reg_ofs_t TMR_CTRL_OFS   = 12'h008;
	localparam reg_ofs_t TMR_STRIDE     = 12'h010;

	// interrupt controller registers
	localparam reg_ofs_t IRQ_STATUS_OFS = 12'h000;
	localparam reg_ofs_t IRQ_ENABLE_OFS = 12'h004;
	localparam reg_ofs_t IRQ_CLEAR_OFS  = 12'h008;

endpackage
